/* include/arcade_cfg.svh */
// configuration constants for the arcade core glue
// bridge register map, data table slots, controller key bits and video delay

`ifndef ARCADE_CFG_SVH
`define ARCADE_CFG_SVH

// bridge register map, one word each
`define REG_PLAYERS_ADDR   32'h8000_0000
`define REG_BONUS_ADDR     32'h9000_0000
`define REG_ROM_SIZE_ADDR  32'hF800_0000

// host data table
`define SAVE_SIZE          32'd65536
`define DT_ROM_SIZE_ADDR   10'd1
`define DT_SAVE_SIZE_ADDR  10'd3

// controllers
`define SYNC_STAGES        3
`define NUM_PLAYERS        2

// bit positions in the controller key bitmap
`define KEY_UP             0
`define KEY_DOWN           1
`define KEY_LEFT           2
`define KEY_RIGHT          3
`define KEY_FIRE           4
`define KEY_SELECT         14
`define KEY_START          15

// pixel steps between the raw and the used horizontal blank
`define HBLANK_DELAY       9

`endif

/* verilog/arcade_pkg.sv */
// shared types of the arcade core glue
// register selects, poller phases and the bus and pixel widths

`default_nettype none

package arcade_pkg;

    // bridge register decode
    typedef enum logic [1:0] {
        sel_players,
        sel_bonus,
        sel_rom_size,
        sel_none
    } bridge_reg_e;

    // data table poller, read the rom size or write the save size
    typedef enum logic {
        phase_read_rom,
        phase_write_save
    } poll_phase_e;

    typedef logic [15:0] key_map_t;
    // bit 0 up, 1 down, 2 left, 3 right, 4 fire, all active low
    typedef logic [4:0]  stick_n_t;
    typedef logic [1:0]  setting_t;
    // red 7:5, green 4:2, blue 1:0
    typedef logic [7:0]  rgb332_t;
    typedef logic [31:0] word_t;
    typedef logic [9:0]  dt_addr_t;

endpackage

`default_nettype wire

/* verilog/bridge_apb_regs.sv */
// APB slave for the core settings
// players and bonus registers, rom size read-back, error on unmapped addresses

`default_nettype none

`include "arcade_cfg.svh"

module bridge_apb_regs (
    input  wire                     clk_74a,
    input  wire                     pll_core_locked,
    input  wire arcade_pkg::word_t  paddr,
    input  wire                     psel,
    input  wire                     penable,
    input  wire                     pwrite,
    input  wire arcade_pkg::word_t  pwdata,
    input  wire arcade_pkg::word_t  rom_file_size,
    output arcade_pkg::word_t       prdata,
    output logic                    pready,
    output logic                    pslverr,
    output arcade_pkg::setting_t    players,
    output arcade_pkg::setting_t    bonus
);
    import arcade_pkg::*;

    bridge_reg_e reg_sel;
    logic        access;

    always_comb begin
        case (paddr)
            `REG_PLAYERS_ADDR:  reg_sel = sel_players;
            `REG_BONUS_ADDR:    reg_sel = sel_bonus;
            `REG_ROM_SIZE_ADDR: reg_sel = sel_rom_size;
            default:            reg_sel = sel_none;
        endcase
    end

    // access phase, no wait states
    assign access  = psel & penable;
    assign pready  = 1'b1;
    assign pslverr = access & (reg_sel == sel_none);

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            players <= '0;
            bonus   <= '0;
        end else if (access && pwrite) begin
            case (reg_sel)
                sel_players: players <= pwdata[1:0];
                sel_bonus:   bonus   <= pwdata[1:0];
                default: ;
            endcase
        end
    end

    // read mux, unmapped reads return zero
    always_comb begin
        case (reg_sel)
            sel_players:  prdata = word_t'(players);
            sel_bonus:    prdata = word_t'(bonus);
            sel_rom_size: prdata = rom_file_size;
            default:      prdata = '0;
        endcase
    end

    // every access phase follows a setup phase on the same select
    a_apb_setup: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        penable |-> psel && $past(psel))
        else $error("penable without a preceding setup phase");

endmodule

`default_nettype wire

/* verilog/datatable_poller.sv */
// host data table poller
// eight-step loop, rom size read and save size write

`default_nettype none

`include "arcade_cfg.svh"

module datatable_poller (
    input  wire                     clk_74a,
    input  wire                     pll_core_locked,
    input  wire arcade_pkg::word_t  datatable_q,
    output arcade_pkg::dt_addr_t    datatable_addr,
    output logic                    datatable_wren,
    output arcade_pkg::word_t       datatable_data,
    output arcade_pkg::word_t       rom_file_size
);
    import arcade_pkg::*;

    logic [2:0]  step;
    poll_phase_e phase;

    // counts 5 to 7 write, the rest read
    assign phase = (step > 3'd4) ? phase_write_save : phase_read_rom;

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            step           <= '0;
            datatable_addr <= '0;
            datatable_wren <= 1'b0;
            datatable_data <= '0;
            rom_file_size  <= '0;
        end else begin
            step <= step + 3'd1;
            case (phase)
                phase_read_rom: begin
                    datatable_wren <= 1'b0;
                    datatable_addr <= `DT_ROM_SIZE_ADDR;
                    // address has been stable for a few steps by now
                    if (step == 3'd4)
                        rom_file_size <= datatable_q;
                end
                phase_write_save: begin
                    datatable_wren <= 1'b1;
                    datatable_addr <= `DT_SAVE_SIZE_ADDR;
                    datatable_data <= `SAVE_SIZE;
                end
            endcase
        end
    end

    a_wren_slot: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        datatable_wren |-> datatable_addr == `DT_SAVE_SIZE_ADDR)
        else $error("data table write outside the save size slot");

    // write burst is three cycles per loop
    a_wren_len: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        $rose(datatable_wren) |-> datatable_wren [*3] ##1 !datatable_wren)
        else $error("data table write burst has the wrong length");

endmodule

`default_nettype wire

/* verilog/player_controls.sv */
// one controller
// key bitmap synchronizer and mapping to active-low cabinet signals

`default_nettype none

`include "arcade_cfg.svh"

module player_controls (
    input  wire                        clk_74a,
    input  wire                        pll_core_locked,
    input  wire arcade_pkg::key_map_t  cont_key,
    output arcade_pkg::stick_n_t       stick_n,
    output logic                       start_n,
    output logic                       coin_n
);
    import arcade_pkg::*;

    key_map_t sync_q [`SYNC_STAGES];
    key_map_t key_s;

    //////////////////////////////////////////////////
    // synchronizer
    //////////////////////////////////////////////////

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            sync_q <= '{default: '0};
        end else begin
            sync_q[0] <= cont_key;
            for (int i = 1; i < `SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign key_s = sync_q[`SYNC_STAGES-1];

    //////////////////////////////////////////////////
    // key mapping
    //////////////////////////////////////////////////

    // game inputs are active low
    assign stick_n = ~{key_s[`KEY_FIRE], key_s[`KEY_RIGHT], key_s[`KEY_LEFT],
                       key_s[`KEY_DOWN], key_s[`KEY_UP]};
    assign start_n = ~key_s[`KEY_START];
    // select doubles as the coin button
    assign coin_n  = ~key_s[`KEY_SELECT];

endmodule

`default_nettype wire

/* verilog/cabinet_inputs.sv */
// cabinet input register
// merges both players into one registered word, packs the dip switch byte

`default_nettype none

`include "arcade_cfg.svh"

module cabinet_inputs (
    input  wire                         clk_74a,
    input  wire                         pll_core_locked,
    input  wire arcade_pkg::stick_n_t   stick_n_in [`NUM_PLAYERS],
    input  wire [`NUM_PLAYERS-1:0]      start_n_in,
    input  wire [`NUM_PLAYERS-1:0]      coin_n_in,
    input  wire arcade_pkg::setting_t   players,
    input  wire arcade_pkg::setting_t   bonus,
    output arcade_pkg::stick_n_t        p1_stick_n,
    output arcade_pkg::stick_n_t        p2_stick_n,
    output logic [`NUM_PLAYERS-1:0]     start_n,
    output logic                        coin_n,
    output logic [7:0]                  dip_switch
);
    import arcade_pkg::*;

    localparam int STICK_W = $bits(stick_n_t);
    localparam int CAB_W   = 2 * STICK_W + `NUM_PLAYERS + 1;

    logic [CAB_W-1:0] cab_d;
    logic [CAB_W-1:0] cab_q;

    // one shared coin slot, active when any player inserts
    assign cab_d = {&coin_n_in, start_n_in, stick_n_in[1], stick_n_in[0]};

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            cab_q      <= '1;
            dip_switch <= '0;
        end else begin
            cab_q      <= cab_d;
            // upper four switches unused
            dip_switch <= {4'b0000, bonus, players};
        end
    end

    assign p1_stick_n = cab_q[STICK_W-1:0];
    assign p2_stick_n = cab_q[2*STICK_W-1:STICK_W];
    assign start_n    = cab_q[2*STICK_W+`NUM_PLAYERS-1:2*STICK_W];
    assign coin_n     = cab_q[CAB_W-1];

endmodule

`default_nettype wire

/* verilog/video_formatter.sv */
// video output formatting
// 3-3-2 to 24-bit rgb, data enable, delayed hblank, sync pulses

`default_nettype none

`include "arcade_cfg.svh"

module video_formatter (
    input  wire                         clk_74a,
    input  wire                         pll_core_locked,
    input  wire                         pix_ce,
    input  wire arcade_pkg::rgb332_t    pix_rgb,
    input  wire                         hblank_raw,
    input  wire                         vblank_raw,
    input  wire                         hsync_n,
    input  wire                         vsync_n,
    output logic [23:0]                 video_rgb,
    output logic                        video_de,
    output logic                        video_hs,
    output logic                        video_vs
);
    import arcade_pkg::*;

    logic [`HBLANK_DELAY-1:0] hbl_q;
    logic                     hblank;
    logic                     blank;
    logic                     hs_prev;
    logic                     vs_prev;

    // widen each channel by repeating its bits
    function automatic logic [23:0] expand_rgb(input rgb332_t pix);
        logic [2:0] r;
        logic [2:0] g;
        logic [1:0] b;
        r = pix[7:5];
        g = pix[4:2];
        b = pix[1:0];
        return {r, r, r[2:1], g, g, g[2:1], b, b, b, b};
    endfunction

    // raw hblank leads the pixels, line it up
    assign hblank = hbl_q[`HBLANK_DELAY-1];
    assign blank  = hblank | vblank_raw;

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            hbl_q     <= '0;
            hs_prev   <= 1'b0;
            vs_prev   <= 1'b0;
            video_rgb <= '0;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
        end else begin
            if (pix_ce)
                hbl_q <= {hbl_q[`HBLANK_DELAY-2:0], hblank_raw};

            video_de <= ~blank;
            // hold the last pixel through blanking
            if (!blank)
                video_rgb <= expand_rgb(pix_rgb);

            // one pulse per falling sync
            video_hs <= ~hsync_n & ~hs_prev;
            video_vs <= ~vsync_n & ~vs_prev;
            hs_prev  <= ~hsync_n;
            vs_prev  <= ~vsync_n;
        end
    end

    a_hs_pulse: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
        video_hs |=> !video_hs)
        else $error("video_hs high for more than one cycle");

endmodule

`default_nettype wire

/* verilog/arcade_core_top.sv */
// arcade core glue top level
// settings bus, data table poller, controllers, cabinet inputs, video

`default_nettype none

`include "arcade_cfg.svh"

module arcade_core_top (
    input  wire                         clk_74a,
    input  wire                         pll_core_locked,

    // settings bus
    input  wire arcade_pkg::word_t      paddr,
    input  wire                         psel,
    input  wire                         penable,
    input  wire                         pwrite,
    input  wire arcade_pkg::word_t      pwdata,
    output wire arcade_pkg::word_t      prdata,
    output wire                         pready,
    output wire                         pslverr,

    // host data table
    output wire arcade_pkg::dt_addr_t   datatable_addr,
    output wire                         datatable_wren,
    output wire arcade_pkg::word_t      datatable_data,
    input  wire arcade_pkg::word_t      datatable_q,

    // controllers and cabinet
    input  wire arcade_pkg::key_map_t   cont1_key,
    input  wire arcade_pkg::key_map_t   cont2_key,
    output wire arcade_pkg::stick_n_t   p1_stick_n,
    output wire arcade_pkg::stick_n_t   p2_stick_n,
    output wire [1:0]                   start_n,
    output wire                         coin_n,
    output wire [7:0]                   dip_switch,

    // video from the game and to the scaler
    input  wire                         pix_ce,
    input  wire arcade_pkg::rgb332_t    pix_rgb,
    input  wire                         hblank_raw,
    input  wire                         vblank_raw,
    input  wire                         hsync_n,
    input  wire                         vsync_n,
    output wire [23:0]                  video_rgb,
    output wire                         video_de,
    output wire                         video_hs,
    output wire                         video_vs
);

    wire arcade_pkg::setting_t  players;
    wire arcade_pkg::setting_t  bonus;
    wire arcade_pkg::word_t     rom_file_size;
    wire arcade_pkg::key_map_t  cont_key_w [`NUM_PLAYERS];
    wire arcade_pkg::stick_n_t  stick_n_w [`NUM_PLAYERS];
    wire [`NUM_PLAYERS-1:0]     start_n_w;
    wire [`NUM_PLAYERS-1:0]     coin_n_w;

    assign cont_key_w[0] = cont1_key;
    assign cont_key_w[1] = cont2_key;

    //////////////////////////////////////////////////
    // bridge and data table
    //////////////////////////////////////////////////

    bridge_apb_regs u_bridge (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .paddr           (paddr),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .pwdata          (pwdata),
        .rom_file_size   (rom_file_size),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .players         (players),
        .bonus           (bonus)
    );

    datatable_poller u_poller (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .datatable_q     (datatable_q),
        .datatable_addr  (datatable_addr),
        .datatable_wren  (datatable_wren),
        .datatable_data  (datatable_data),
        .rom_file_size   (rom_file_size)
    );

    //////////////////////////////////////////////////
    // controls
    //////////////////////////////////////////////////

    for (genvar i = 0; i < `NUM_PLAYERS; i++) begin : g_player
        player_controls u_player (
            .clk_74a         (clk_74a),
            .pll_core_locked (pll_core_locked),
            .cont_key        (cont_key_w[i]),
            .stick_n         (stick_n_w[i]),
            .start_n         (start_n_w[i]),
            .coin_n          (coin_n_w[i])
        );
    end

    cabinet_inputs u_cabinet (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .stick_n_in      (stick_n_w),
        .start_n_in      (start_n_w),
        .coin_n_in       (coin_n_w),
        .players         (players),
        .bonus           (bonus),
        .p1_stick_n      (p1_stick_n),
        .p2_stick_n      (p2_stick_n),
        .start_n         (start_n),
        .coin_n          (coin_n),
        .dip_switch      (dip_switch)
    );

    //////////////////////////////////////////////////
    // video
    //////////////////////////////////////////////////

    video_formatter u_video (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .pix_ce          (pix_ce),
        .pix_rgb         (pix_rgb),
        .hblank_raw      (hblank_raw),
        .vblank_raw      (vblank_raw),
        .hsync_n         (hsync_n),
        .vsync_n         (vsync_n),
        .video_rgb       (video_rgb),
        .video_de        (video_de),
        .video_hs        (video_hs),
        .video_vs        (video_vs)
    );

endmodule

`default_nettype wire

/* verif/arcade_checker.sv */
// testbench checker for the arcade core glue
// watches bus, data table, cabinet and video, counts errors, prints results

`default_nettype none

`include "arcade_cfg.svh"

module arcade_checker (
    input  wire         clk_74a,
    input  wire         pll_core_locked,
    input  wire [31:0]  paddr,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire [31:0]  pwdata,
    input  wire [31:0]  prdata,
    input  wire         pready,
    input  wire         pslverr,
    input  wire [9:0]   datatable_addr,
    input  wire         datatable_wren,
    input  wire [31:0]  datatable_data,
    input  wire [31:0]  datatable_q,
    input  wire [15:0]  cont1_key,
    input  wire [15:0]  cont2_key,
    input  wire [4:0]   p1_stick_n,
    input  wire [4:0]   p2_stick_n,
    input  wire [1:0]   start_n,
    input  wire         coin_n,
    input  wire [7:0]   dip_switch,
    input  wire         pix_ce,
    input  wire [7:0]   pix_rgb,
    input  wire         hblank_raw,
    input  wire         vblank_raw,
    input  wire         hsync_n,
    input  wire         vsync_n,
    input  wire [23:0]  video_rgb,
    input  wire         video_de,
    input  wire         video_hs,
    input  wire         video_vs,
    input  wire         test_done,
    input  wire [7:0]   test_tag,
    input  wire         all_done,
    output int          error_count,
    output int          test_count
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [1:0]  sh_players;
    logic [1:0]  sh_bonus;
    logic [7:0]  dip_exp;
    logic [15:0] k1_hist [4];
    logic [15:0] k2_hist [4];
    logic [7:0]  wr_hist;
    logic [31:0] rom_track;
    int          rom_age;
    int          live;
    logic [`HBLANK_DELAY-1:0] hbl_m;
    logic        blank_m;
    logic        exp_de;
    logic [23:0] exp_rgb;
    logic        exp_hs;
    logic        exp_vs;
    logic        hs_prev_n;
    logic        vs_prev_n;
    int          test_errs;
    int          pass_count;
    logic [31:0] exp_rd;

    task automatic report_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        test_errs++;
        error_count++;
    endtask

    // each channel bit repeats the channel from its msb down
    function automatic logic [23:0] widen_pixel(input logic [7:0] pix);
        logic [23:0] out;
        for (int i = 0; i < 8; i++) begin
            out[23-i] = pix[7 - (i % 3)];
            out[15-i] = pix[4 - (i % 3)];
            out[7-i]  = pix[1 - (i % 2)];
        end
        return out;
    endfunction

    function automatic logic [4:0] stick_of(input logic [15:0] key);
        return ~{key[`KEY_FIRE], key[`KEY_RIGHT], key[`KEY_LEFT], key[`KEY_DOWN],
                 key[`KEY_UP]};
    endfunction

    assign blank_m = hbl_m[`HBLANK_DELAY-1] | vblank_raw;

    always @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            sh_players <= '0;
            sh_bonus   <= '0;
            dip_exp    <= '0;
            k1_hist    <= '{default: '0};
            k2_hist    <= '{default: '0};
            wr_hist    <= '0;
            rom_track  <= '0;
            rom_age    <= 0;
            live       <= 0;
            hbl_m      <= '0;
            exp_de     <= 1'b0;
            exp_rgb    <= '0;
            exp_hs     <= 1'b0;
            exp_vs     <= 1'b0;
            hs_prev_n  <= 1'b1;
            vs_prev_n  <= 1'b1;
        end else begin
            if (live < 1000)
                live <= live + 1;

            //////////////////////////////////////////////////
            // data table
            //////////////////////////////////////////////////
            wr_hist <= {wr_hist[6:0], datatable_wren};
            if (datatable_wren && (datatable_addr != `DT_SAVE_SIZE_ADDR ||
                                   datatable_data != `SAVE_SIZE))
                report_error("data table write with wrong address or data");
            if (live >= 9 && $countones(wr_hist) != 3)
                report_error("data table write not 3 of 8 cycles");
            if (datatable_addr == `DT_ROM_SIZE_ADDR && datatable_q != rom_track) begin
                rom_track <= datatable_q;
                rom_age   <= 0;
            end else if (rom_age < 1000) begin
                rom_age <= rom_age + 1;
            end

            //////////////////////////////////////////////////
            // settings bus
            //////////////////////////////////////////////////
            if (psel && penable) begin
                if (!pready)
                    report_error("pready low in the access phase");
                if (pslverr != !(paddr == `REG_PLAYERS_ADDR || paddr == `REG_BONUS_ADDR ||
                                 paddr == `REG_ROM_SIZE_ADDR))
                    report_error($sformatf("pslverr %0b for address %h", pslverr, paddr));
                if (pwrite) begin
                    if (paddr == `REG_PLAYERS_ADDR)
                        sh_players <= pwdata[1:0];
                    if (paddr == `REG_BONUS_ADDR)
                        sh_bonus <= pwdata[1:0];
                end else begin
                    exp_rd = 32'd0;
                    if (paddr == `REG_PLAYERS_ADDR)
                        exp_rd = {30'd0, sh_players};
                    if (paddr == `REG_BONUS_ADDR)
                        exp_rd = {30'd0, sh_bonus};
                    if (paddr == `REG_ROM_SIZE_ADDR)
                        exp_rd = rom_track;
                    // rom size is only defined once the table value has settled
                    if (prdata != exp_rd && !(paddr == `REG_ROM_SIZE_ADDR && rom_age < 16))
                        report_error($sformatf("read %h gave %h, expected %h",
                                               paddr, prdata, exp_rd));
                end
            end
            dip_exp <= {4'b0000, sh_bonus, sh_players};
            if (live >= 2 && dip_switch != dip_exp)
                report_error($sformatf("dip_switch %h, expected %h", dip_switch, dip_exp));

            //////////////////////////////////////////////////
            // cabinet inputs four cycles behind the keys
            //////////////////////////////////////////////////
            k1_hist[0] <= cont1_key;
            k2_hist[0] <= cont2_key;
            for (int i = 1; i < 4; i++) begin
                k1_hist[i] <= k1_hist[i-1];
                k2_hist[i] <= k2_hist[i-1];
            end
            if (p1_stick_n != stick_of(k1_hist[3]) || p2_stick_n != stick_of(k2_hist[3]))
                report_error($sformatf("sticks %h %h for keys %h %h", p1_stick_n,
                                       p2_stick_n, k1_hist[3], k2_hist[3]));
            if (start_n != ~{k2_hist[3][`KEY_START], k1_hist[3][`KEY_START]})
                report_error($sformatf("start_n %b wrong", start_n));
            if (coin_n != ~(k1_hist[3][`KEY_SELECT] | k2_hist[3][`KEY_SELECT]))
                report_error($sformatf("coin_n %b wrong", coin_n));

            //////////////////////////////////////////////////
            // video
            //////////////////////////////////////////////////
            if (pix_ce)
                hbl_m <= {hbl_m[`HBLANK_DELAY-2:0], hblank_raw};
            exp_de <= !blank_m;
            if (!blank_m)
                exp_rgb <= widen_pixel(pix_rgb);
            exp_hs    <= !hsync_n && hs_prev_n;
            exp_vs    <= !vsync_n && vs_prev_n;
            hs_prev_n <= hsync_n;
            vs_prev_n <= vsync_n;
            if (video_de != exp_de)
                report_error($sformatf("video_de %b, expected %b", video_de, exp_de));
            if (video_rgb != exp_rgb)
                report_error($sformatf("video_rgb %h, expected %h", video_rgb, exp_rgb));
            if (video_hs != exp_hs || video_vs != exp_vs)
                report_error($sformatf("sync pulses %b %b, expected %b %b",
                                       video_hs, video_vs, exp_hs, exp_vs));

            if (test_done) begin
                test_count++;
                if (test_errs == 0) begin
                    pass_count++;
                    $display("test %0d (%c): ok", test_count, test_tag);
                end else begin
                    $display("test %0d (%c): %0d errors", test_count, test_tag, test_errs);
                end
                test_errs = 0;
            end
            if (all_done)
                $display("summary: %0d tests, %0d passed, %0d errors",
                         test_count, pass_count, error_count);
        end
    end

    initial begin
        error_count = 0;
        test_count  = 0;
        test_errs   = 0;
        pass_count  = 0;
    end

endmodule

`default_nettype wire

/* verif/tb_arcade_core.sv */
// testbench top for the arcade core glue
// clock, reset, pattern reader, stimulus tasks, data table model, timeout

`default_nettype none

`include "arcade_cfg.svh"

module tb_arcade_core;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk_74a = 1'b0;
    logic        pll_core_locked;
    logic [31:0] paddr, pwdata, prdata, datatable_data, datatable_q, rom_size;
    logic        psel, penable, pwrite, pready, pslverr;
    logic [9:0]  datatable_addr;
    logic        datatable_wren;
    logic [15:0] cont1_key, cont2_key;
    logic [4:0]  p1_stick_n, p2_stick_n;
    logic [1:0]  start_n;
    logic        coin_n;
    logic [7:0]  dip_switch;
    logic        pix_ce, hblank_raw, vblank_raw, hsync_n, vsync_n;
    logic [7:0]  pix_rgb;
    logic [23:0] video_rgb;
    logic        video_de, video_hs, video_vs;
    logic        test_done, all_done;
    logic [7:0]  test_tag;
    int          error_count, test_count;

    logic [7:0]  pat_tag [64];
    logic [31:0] pat_a [64];
    logic [31:0] pat_b [64];
    int          num_pats = 0;
    int          cycles = 0;
    int          cycle_limit = 100000;
    logic [31:0] seed = 32'h75ad_2aa6;

    always #20 clk_74a = ~clk_74a;

    // host data table model with one readable slot
    assign datatable_q = (datatable_addr == `DT_ROM_SIZE_ADDR) ? rom_size : 32'h0bad_0bad;

    arcade_core_top UUT (.*);

    arcade_checker u_checker (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    //////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////

    task automatic apb_access(input logic [31:0] addr, input logic wr, input logic [31:0] data);
        @(posedge clk_74a);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk_74a);
        penable <= 1'b1;
        @(posedge clk_74a);
        while (!pready)
            @(posedge clk_74a);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic drive_video(input int n, input logic do_hblank, input logic do_sync);
        for (int i = 0; i < n; i++) begin
            @(posedge clk_74a);
            seed = xorshift(seed);
            pix_rgb    <= seed[7:0];
            pix_ce     <= i[0];
            hblank_raw <= do_hblank && (i == 2 || i == 3);
            hsync_n    <= !(do_sync && i >= 2 && i <= 4);
            vsync_n    <= !(do_sync && i >= 3 && i <= 7);
        end
        @(posedge clk_74a);
        pix_ce <= 1'b0;
    endtask

    task automatic load_patterns();
        int    fd;
        int    n;
        string line;
        fd = $fopen("verif/arcade_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
        end else begin
            while (!$feof(fd) && num_pats < 64) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    pat_a[num_pats] = '0;
                    pat_b[num_pats] = '0;
                    n = $sscanf(line, "%c %h %h", pat_tag[num_pats], pat_a[num_pats],
                                pat_b[num_pats]);
                    num_pats++;
                end
            end
            $fclose(fd);
        end
    endtask

    // runaway guard sized from the pattern count
    always @(posedge clk_74a) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        pll_core_locked = 1'b0;
        paddr = '0;
        pwdata = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        rom_size = '0;
        cont1_key = '0;
        cont2_key = '0;
        pix_ce = 1'b0;
        pix_rgb = '0;
        hblank_raw = 1'b0;
        vblank_raw = 1'b0;
        hsync_n = 1'b1;
        vsync_n = 1'b1;
        test_done = 1'b0;
        test_tag = '0;
        all_done = 1'b0;
        load_patterns();
        cycle_limit = 64 * num_pats + 1000;

        repeat (8) @(posedge clk_74a);
        pll_core_locked <= 1'b1;
        repeat (4) @(posedge clk_74a);

        for (int i = 0; i < num_pats; i++) begin
            case (pat_tag[i])
                "P": begin
                    apb_access(`REG_PLAYERS_ADDR, 1'b1, pat_a[i]);
                    apb_access(`REG_PLAYERS_ADDR, 1'b0, '0);
                end
                "B": begin
                    apb_access(`REG_BONUS_ADDR, 1'b1, pat_a[i]);
                    apb_access(`REG_BONUS_ADDR, 1'b0, '0);
                end
                "U": begin
                    apb_access(pat_a[i], 1'b1, 32'hffff_ffff);
                    apb_access(pat_a[i], 1'b0, '0);
                end
                "K": begin
                    @(posedge clk_74a);
                    cont1_key <= pat_a[i][15:0];
                    cont2_key <= pat_b[i][15:0];
                end
                "D": begin
                    @(posedge clk_74a);
                    rom_size <= pat_a[i];
                    repeat (20) @(posedge clk_74a);
                    apb_access(`REG_ROM_SIZE_ADDR, 1'b0, '0);
                end
                "V": drive_video(int'(pat_a[i]), 1'b0, 1'b0);
                "H": drive_video(40, 1'b1, 1'b0);
                "S": drive_video(16, 1'b0, 1'b1);
                default: $display("unknown test letter %c in the pattern file", pat_tag[i]);
            endcase
            // settle key and dip latency before closing the test
            repeat (6) @(posedge clk_74a);
            test_tag  <= pat_tag[i];
            test_done <= 1'b1;
            @(posedge clk_74a);
            test_done <= 1'b0;
        end

        all_done <= 1'b1;
        @(posedge clk_74a);
        all_done <= 1'b0;
        @(posedge clk_74a);
        if (error_count == 0 && test_count == num_pats && num_pats > 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

/* arcade_core_top.f */
+incdir+include
verilog/arcade_pkg.sv
verilog/bridge_apb_regs.sv
verilog/datatable_poller.sv
verilog/player_controls.sv
verilog/cabinet_inputs.sv
verilog/video_formatter.sv
verilog/arcade_core_top.sv
verif/arcade_checker.sv
verif/tb_arcade_core.sv

/* run_sim.sh */
#!/bin/sh
# build and run the arcade core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f arcade_core_top.f \
    --top-module tb_arcade_core \
    -o sim_tb_arcade_core
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_tb_arcade_core)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

/* verif/arcade_patterns.txt */
# test letter then hex fields: P/B data, U addr, K key1 key2, D rom size,
# V pixel cycles, H hblank pulse, S sync pulses
P 00000003
B 00000002
P 0000000d
B ffffffff
U 12345678
U 80000004
P 00000000
K 0001 0000
K 0000 0002
K 0014 0008
K 4000 0000
K 0000 4000
K 8000 0000
K c01f 801f
K 0000 0000
D 00012345
D 00400000
V 00000020
H
S
V 00000040
B 00000001
S
